// File: files.f
stdp_pkg.sv
stdp_pair_if.sv
spike_history.sv
spike_timing.sv
plasticity_decision.sv
weight_store.sv
stdp_synapse_top.sv
stdp_checker.sv
tb_stdp.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_stdp
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_stdp.sv
`timescale 1ns/1ps

module tb_stdp;

  localparam int                N_SYN       = 16;
  localparam stdp_pkg::weight_t INIT_WEIGHT = 16'd2;

  logic               clock = 1'b0;
  logic               rst;
  logic               shift;
  logic               post_spike;
  logic               learn;
  logic [N_SYN-1:0]   pre_spike;
  stdp_pkg::syn_idx_t syn_sel;
  stdp_pkg::syn_idx_t rd_sel;
  stdp_pkg::weight_t  rd_weight;
  logic               upd_valid;
  logic               upd_fire;
  logic               upd_up;

  logic [15:0]       lfsr_state = 16'd32120; // Stimulus LFSR
  stdp_pkg::hist_t   post_h;                  // Model of the post history
  stdp_pkg::hist_t   pre_h [N_SYN];
  stdp_pkg::weight_t w_exp [N_SYN];           // Expected weights

  stdp_synapse_top dut0 (
    .clock      (clock),
    .rst        (rst),
    .shift      (shift),
    .post_spike (post_spike),
    .learn      (learn),
    .pre_spike  (pre_spike),
    .syn_sel    (syn_sel),
    .rd_sel     (rd_sel),
    .rd_weight  (rd_weight),
    .upd_valid  (upd_valid),
    .upd_fire   (upd_fire),
    .upd_up     (upd_up)
  );

  bind plasticity_decision stdp_checker chk0 (
    .clock      (clock),
    .rst        (rst),
    .learn      (timing0.learn),
    .upd_valid  (upd_valid),
    .upd_fire   (upd_fire)
  );

  always #5 clock = ~clock; // 10 ns period

  //////////////////////////////
  // Helpers
  //////////////////////////////
  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Nearest pairing, 0 when there is none
  function automatic int pair_dt(input stdp_pkg::hist_t post, input stdp_pkg::hist_t pre,
                                 output logic ltd);
    stdp_pkg::hist_t s;
    ltd = !post[15] && pre[15];
    if (post[15])
      s = pre;
    else if (pre[15])
      s = post;
    else
      return 0;
    for (int d = 0; d <= 12; d++)
    begin
      if (s[15-d])
        return d;
    end
    return 0; // Partner too old
  endfunction

  task automatic stop_with_error();
    $display("Finished with errors");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_eq(input string what, input int got, input int exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      stop_with_error();
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1; // Drive point
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (2) @(posedge clock);
    #1;
    rst = 1'b0;
    post_h = '0;
    for (int i = 0; i < N_SYN; i++)
    begin
      pre_h[i] = '0;
      w_exp[i] = INIT_WEIGHT;
    end
  endtask

  task automatic shift_in(input logic post, input logic [N_SYN-1:0] pre);
    shift      = 1'b1;
    post_spike = post;
    pre_spike  = pre;
    next_cycle();
    shift      = 1'b0;
    post_spike = 1'b0;
    pre_spike  = '0;
    post_h     = {post, post_h[15:1]}; // Newest at the top
    for (int i = 0; i < N_SYN; i++)
      pre_h[i] = {pre[i], pre_h[i][15:1]};
  endtask

  // Direction or silence from the model, then weight rule
  task automatic check_pairing(input int syn, input logic fire, input logic up);
    logic ltd;
    int   dt;
    dt = pair_dt(post_h, pre_h[syn], ltd);
    if (dt == 0)
      check_eq("upd_fire with no pairing", int'(fire), 0);
    else
      check_eq("upd_up", int'(up), int'(!ltd));
    if (fire && up && w_exp[syn] != '1)
      w_exp[syn] = w_exp[syn] + 16'd1;
    else if (fire && !up && w_exp[syn] != '0)
      w_exp[syn] = w_exp[syn] - 16'd1;
  endtask

  task automatic do_learn(input int syn, output logic fire, output logic up);
    int cyc;
    cyc     = 0;
    syn_sel = stdp_pkg::syn_idx_t'(syn);
    rd_sel  = stdp_pkg::syn_idx_t'(syn);
    learn   = 1'b1;
    do
    begin
      next_cycle();
      learn = 1'b0;
      cyc++;
      if (cyc > 8)
      begin
        $display("Timeout: upd_valid never came after learn at %0t ns", $time);
        stop_with_error();
      end
    end
    while (!upd_valid);
    check_eq("learn to upd_valid cycles", cyc, 2);
    fire = upd_fire;
    up   = upd_up;
    check_pairing(syn, fire, up);
    next_cycle(); // Weight visible from cycle 3
    check_eq("rd_weight after update", int'(rd_weight), int'(w_exp[syn]));
  endtask

  // Learn strobes on consecutive cycles, responses collected as they come
  task automatic learn_burst(input int syn, input int n);
    int cyc;
    int got;
    cyc     = 0;
    got     = 0;
    syn_sel = stdp_pkg::syn_idx_t'(syn);
    learn   = 1'b1;
    while (got < n)
    begin
      next_cycle();
      cyc++;
      if (cyc >= n)
        learn = 1'b0;
      if (upd_valid)
      begin
        check_pairing(syn, upd_fire, upd_up);
        got++;
      end
      if (cyc > n + 8)
      begin
        $display("Timeout: burst responses missing at %0t ns", $time);
        stop_with_error();
      end
    end
  endtask

  task automatic check_all_weights();
    next_cycle(); // Last write lands
    for (int i = 0; i < N_SYN; i++)
    begin
      rd_sel = stdp_pkg::syn_idx_t'(i);
      #1;
      check_eq("rd_weight", int'(rd_weight), int'(w_exp[i]));
      next_cycle();
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  task automatic test_reset();
    apply_reset();
    for (int c = 0; c < 5; c++)
    begin
      check_eq("upd_valid without learn", int'(upd_valid), 0);
      next_cycle();
    end
    check_all_weights();
  endtask

  task automatic test_ltp();
    logic fire;
    logic up;
    int   fires;
    apply_reset();
    for (int d = 1; d <= 12; d++)
    begin
      shift_in(1'b0, 16'h0002); // Pre on synapse 1
      repeat (d - 1) shift_in(1'b0, '0);
      shift_in(1'b1, '0);       // Post newest
      fires = 0;
      for (int k = 0; k < ((d == 1) ? 64 : 4); k++)
      begin
        do_learn(1, fire, up);
        fires += int'(fire);
      end
      if (d == 1 && fires < 48)
      begin
        $display("Only %0d of 64 learns fired at dt 1", fires);
        stop_with_error();
      end
    end
  endtask

  task automatic test_ltd();
    logic fire;
    logic up;
    apply_reset();
    shift_in(1'b1, '0);
    shift_in(1'b0, 16'h0004); // Pre on synapse 2 one step after post
    for (int k = 0; k < 12; k++)
      do_learn(2, fire, up);
    check_eq("weight at the floor", int'(rd_weight), 0);
  endtask

  task automatic test_none();
    logic fire;
    logic up;
    apply_reset();
    shift_in(1'b0, 16'h0008);
    shift_in(1'b0, '0);       // Neither newest bit set
    do_learn(3, fire, up);
    shift_in(1'b1, 16'h0008); // Both newest, dt 0
    do_learn(3, fire, up);
    apply_reset();
    shift_in(1'b0, 16'h0010);
    repeat (12) shift_in(1'b0, '0);
    shift_in(1'b1, '0);       // Pre 13 shifts back
    do_learn(4, fire, up);
    check_eq("weight unchanged", int'(rd_weight), int'(INIT_WEIGHT));
  endtask

  task automatic test_random();
    logic             post_bit;
    logic [N_SYN-1:0] pre_bits;
    apply_reset();
    for (int r = 0; r < 20; r++)
    begin
      repeat (3)
      begin
        post_bit = rand_bits(1) != '0;
        pre_bits = rand_bits(N_SYN);
        shift_in(post_bit, pre_bits);
      end
      learn_burst(5, 4);
    end
    check_all_weights(); // Other synapses untouched
  endtask

  initial
  begin
    rst        = 1'b1;
    shift      = 1'b0;
    post_spike = 1'b0;
    learn      = 1'b0;
    pre_spike  = '0;
    syn_sel    = '0;
    rd_sel     = '0;
    test_reset();
    test_ltp();
    test_ltd();
    test_none();
    test_random();
    if (dut0.decide0.chk0.fail_count == 0)
    begin
      $display("Finished with no errors");
      $finish;
    end
    else
    begin
      $display("Checker assertions failed during the run");
      stop_with_error();
    end
  end

endmodule

// File: stdp_checker.sv
`timescale 1ns/1ps

// Protocol checks on the decision stage
module stdp_checker (
  input logic clock,
  input logic rst,
  input logic learn,     // Learn strobe seen by timing detection
  input logic upd_valid,
  input logic upd_fire
);

  int lat_fail  = 0;
  int fire_fail = 0;
  int rst_fail  = 0;
  int fail_count;

  assign fail_count = lat_fail + fire_fail + rst_fail; // Summed for the testbench

  //////////////////////////////
  // Timing
  //////////////////////////////
  // Pairing register plus decision register, so learn to upd_valid is two
  a_latency: assert property (@(posedge clock) disable iff (rst)
    upd_valid == $past(learn, 2))
  else
  begin
    $error("upd_valid is not two cycles behind learn");
    lat_fail++;
  end

  a_fire_valid: assert property (@(posedge clock) disable iff (rst)
    upd_fire |-> upd_valid)
  else
  begin
    $error("upd_fire high without upd_valid");
    fire_fail++;
  end

  // Strobes come out of reset low
  a_reset: assert property (@(posedge clock) rst |=> !upd_valid && !upd_fire)
  else
  begin
    $error("update strobe high right after reset");
    rst_fail++;
  end

endmodule

// File: stdp_synapse_top.sv
`timescale 1ns/1ps

module stdp_synapse_top #(
  parameter int                N_SYN       = 16,    // At most 16
  parameter stdp_pkg::weight_t INIT_WEIGHT = 16'd2,
  parameter logic [7:0]        LFSR_SEED   = 8'hFF
) (
  input  logic               clock,
  input  logic               rst,
  input  logic               shift,
  input  logic               post_spike,
  input  logic               learn,
  input  logic [N_SYN-1:0]   pre_spike,
  input  stdp_pkg::syn_idx_t syn_sel,
  input  stdp_pkg::syn_idx_t rd_sel,
  output stdp_pkg::weight_t  rd_weight,
  output logic               upd_valid,
  output logic               upd_fire,
  output logic               upd_up
);

  stdp_pkg::hist_t    post_hist;
  stdp_pkg::hist_t    pre_hist;
  stdp_pkg::syn_idx_t upd_index;

  stdp_pair_if pair_if0 ();

  spike_history #(
    .N_SYN (N_SYN)
  ) hist0 (
    .clock      (clock),
    .rst        (rst),
    .shift      (shift),
    .post_spike (post_spike),
    .pre_spike  (pre_spike),
    .syn_sel    (syn_sel),
    .post_hist  (post_hist),
    .pre_hist   (pre_hist)
  );

  spike_timing timing0 (
    .clock     (clock),
    .rst       (rst),
    .learn     (learn),
    .syn_sel   (syn_sel),
    .post_hist (post_hist),
    .pre_hist  (pre_hist),
    .pair      (pair_if0.source)
  );

  plasticity_decision #(
    .LFSR_SEED (LFSR_SEED)
  ) decide0 (
    .clock     (clock),
    .rst       (rst),
    .pair      (pair_if0.sink),
    .upd_valid (upd_valid),
    .upd_fire  (upd_fire),
    .upd_up    (upd_up),
    .upd_index (upd_index)
  );

  weight_store #(
    .N_SYN       (N_SYN),
    .INIT_WEIGHT (INIT_WEIGHT)
  ) store0 (
    .clock     (clock),
    .rst       (rst),
    .upd_valid (upd_valid),
    .upd_fire  (upd_fire),
    .upd_up    (upd_up),
    .upd_index (upd_index),
    .rd_sel    (rd_sel),
    .rd_weight (rd_weight)
  );

endmodule

// File: weight_store.sv
`timescale 1ns/1ps

module weight_store #(
  parameter int                N_SYN       = 16,
  parameter stdp_pkg::weight_t INIT_WEIGHT = 16'd2
) (
  input  logic               clock,
  input  logic               rst,
  input  logic               upd_valid,
  input  logic               upd_fire,
  input  logic               upd_up,
  input  stdp_pkg::syn_idx_t upd_index,
  input  stdp_pkg::syn_idx_t rd_sel,
  output stdp_pkg::weight_t  rd_weight
);

  stdp_pkg::weight_t mem [N_SYN];
  stdp_pkg::weight_t cur;    // Weight being updated
  logic              upd_ok; // Index inside the bank

  assign upd_ok = int'(upd_index) < N_SYN;
  assign cur    = upd_ok ? mem[upd_index] : '0;

  //////////////////////////////
  // Saturating update
  //////////////////////////////
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      for (int i = 0; i < N_SYN; i++)
      begin
        mem[i] <= INIT_WEIGHT; // Every synapse restarts equal
      end
    end
    else if (upd_valid && upd_fire && upd_ok)
    begin
      if (upd_up)
      begin
        if (cur != '1)
          mem[upd_index] <= cur + 1'b1; // Hold at the top
      end
      else if (cur != '0)
      begin
        mem[upd_index] <= cur - 1'b1; // Floor at zero
      end
    end
  end

  // Combinational read
  assign rd_weight = (int'(rd_sel) < N_SYN) ? mem[rd_sel] : '0;

endmodule

// File: plasticity_decision.sv
`timescale 1ns/1ps

module plasticity_decision #(
  parameter logic [7:0] LFSR_SEED = 8'hFF // Must be nonzero
) (
  input  logic                clock,
  input  logic                rst,
  stdp_pair_if.sink           pair,
  output logic                upd_valid, // One strobe per learn
  output logic                upd_fire,  // Weight changes this time
  output logic                upd_up,    // Direction of the step
  output stdp_pkg::syn_idx_t  upd_index
);

  logic [7:0]      lfsr_q;
  logic            lfsr_fb;
  stdp_pkg::prob_t prob;
  logic            hit;

  //////////////////////////////
  // Random source
  //////////////////////////////
  // 8-bit Fibonacci LFSR
  assign lfsr_fb = lfsr_q[0] ^ lfsr_q[2] ^ lfsr_q[3] ^ lfsr_q[5];

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      lfsr_q <= LFSR_SEED;
    end
    else
    begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb}; // Free-running step
    end
  end

  //////////////////////////////
  // Table lookup and compare
  //////////////////////////////
  always_comb
  begin
    if (pair.ltd)
    begin
      prob = stdp_pkg::LTD_PROB[pair.dt];
    end
    else
    begin
      prob = stdp_pkg::LTP_PROB[pair.dt];
    end
  end

  // Strictly greater so a zero entry never fires
  assign hit = pair.valid & (prob > lfsr_q);

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      upd_valid <= 1'b0;
      upd_fire  <= 1'b0;
    end
    else
    begin
      upd_valid <= pair.valid;
      upd_fire  <= hit; // Qualified by valid already
    end
  end

  // Direction and target follow the pairing
  always_ff @(posedge clock)
  begin
    if (pair.valid)
    begin
      upd_up    <= ~pair.ltd;
      upd_index <= pair.index;
    end
  end

endmodule

// File: spike_timing.sv
`timescale 1ns/1ps

module spike_timing (
  input  logic               clock,
  input  logic               rst,
  input  logic               learn,    // Learn strobe
  input  stdp_pkg::syn_idx_t syn_sel,
  input  stdp_pkg::hist_t    post_hist,
  input  stdp_pkg::hist_t    pre_hist,
  stdp_pair_if.source        pair
);

  stdp_pkg::hist_t srch;   // History searched for the partner spike
  logic            anchor; // One of the newest bits is set
  logic            ltd_c;
  stdp_pkg::dt_t   dt_c;

  //////////////////////////////
  // Pairing and leading-one search
  //////////////////////////////
  always_comb
  begin
    anchor = post_hist[stdp_pkg::HIST_LEN-1] | pre_hist[stdp_pkg::HIST_LEN-1];
    ltd_c  = ~post_hist[stdp_pkg::HIST_LEN-1] & pre_hist[stdp_pkg::HIST_LEN-1];
    // Post newest means look back through pre, otherwise through post
    srch   = post_hist[stdp_pkg::HIST_LEN-1] ? pre_hist : post_hist;
    dt_c   = '0; // No partner in range reads as dt 0
    // Walk from far to near so the nearest set bit wins
    for (int i = stdp_pkg::MAX_DT; i >= 0; i--)
    begin
      if (srch[stdp_pkg::HIST_LEN-1-i])
      begin
        dt_c = stdp_pkg::dt_t'(i);
      end
    end
    if (!anchor)
    begin
      dt_c = '0; // Nothing new to pair with
    end
  end

  //////////////////////////////
  // Pairing register
  //////////////////////////////
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      pair.valid <= 1'b0;
    end
    else
    begin
      pair.valid <= learn; // High in the cycle after learn
    end
  end

  // Payload only captured on learn
  always_ff @(posedge clock)
  begin
    if (learn)
    begin
      pair.index <= syn_sel;
      pair.ltd   <= ltd_c;
      pair.dt    <= dt_c;
    end
  end

endmodule

// File: spike_history.sv
`timescale 1ns/1ps

module spike_history #(
  parameter int N_SYN = 16
) (
  input  logic               clock,
  input  logic               rst,
  input  logic               shift,     // History shift strobe
  input  logic               post_spike,
  input  logic [N_SYN-1:0]   pre_spike,
  input  stdp_pkg::syn_idx_t syn_sel,
  output stdp_pkg::hist_t    post_hist,
  output stdp_pkg::hist_t    pre_hist
);

  stdp_pkg::hist_t post_q;
  stdp_pkg::hist_t pre_q [N_SYN];

  //////////////////////////////
  // Shift registers
  //////////////////////////////
  // New sample enters at the top, oldest drops off bit 0
  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      post_q <= '0;
      for (int i = 0; i < N_SYN; i++)
      begin
        pre_q[i] <= '0;
      end
    end
    else if (shift)
    begin
      post_q <= {post_spike, post_q[stdp_pkg::HIST_LEN-1:1]};
      for (int i = 0; i < N_SYN; i++)
      begin
        pre_q[i] <= {pre_spike[i], pre_q[i][stdp_pkg::HIST_LEN-1:1]};
      end
    end
  end

  assign post_hist = post_q;

  // Synapse select, unused indices read as silent
  assign pre_hist = (int'(syn_sel) < N_SYN) ? pre_q[syn_sel] : '0;

endmodule

// File: stdp_pair_if.sv
`timescale 1ns/1ps

// Detected pre/post pairing, one strobe per learn
interface stdp_pair_if;
  logic               valid; // Single-cycle strobe
  stdp_pkg::syn_idx_t index; // Synapse that was learned
  logic               ltd;   // Set for depression
  stdp_pkg::dt_t      dt;    // Distance to nearest partner spike

  // Timing detection side
  modport source (
    output valid,
    output index,
    output ltd,
    output dt
  );

  // Plasticity decision side
  modport sink (
    input valid,
    input index,
    input ltd,
    input dt
  );

endinterface

// File: stdp_pkg.sv
package stdp_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int HIST_LEN  = 16; // Spike history depth
  localparam int MAX_DT    = 12; // Last dt with a table entry
  localparam int SYN_IDX_W = 4;  // Up to 16 synapses
  localparam int WEIGHT_W  = 16;
  localparam int DT_W      = $clog2(MAX_DT + 1);

  typedef logic [HIST_LEN-1:0]  hist_t;    // Bit 15 holds the newest sample
  typedef logic [SYN_IDX_W-1:0] syn_idx_t;
  typedef logic [DT_W-1:0]      dt_t;      // Unsigned pairing distance
  typedef logic [7:0]           prob_t;    // Probability scaled to 0..255
  typedef logic [WEIGHT_W-1:0]  weight_t;  // Unsigned synaptic weight

  //////////////////////////////
  // Update probability tables
  //////////////////////////////
  // Indexed by dt, entry 0 never fires
  localparam prob_t LTP_PROB [0:MAX_DT] = '{
    8'd0,   8'd255, 8'd199, 8'd155,
    8'd120, 8'd94,  8'd73,  8'd57,
    8'd44,  8'd35,  8'd27,  8'd21,
    8'd16
  };

  // Depression decays more slowly than potentiation
  localparam prob_t LTD_PROB [0:MAX_DT] = '{
    8'd0,   8'd255, 8'd225, 8'd199,
    8'd175, 8'd155, 8'd136, 8'd120,
    8'd106, 8'd94,  8'd83,  8'd73,
    8'd64
  };

endpackage
